// ==== flu_binder.f ====
+incdir+sim
src/flu_pkg.sv
src/binder_pkg.sv
src/flu_skid_buffer.sv
src/frame_arbiter.sv
src/flu_frame_mux.sv
src/flu_binder.sv
sim/flu_binder_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := flu_binder_tb
FILELIST  := flu_binder.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Exit status of the simulation is the test result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/flu_frame_model.svh ====
/*
 * Reference model for the frame binder testbench
 * Expected-word queues per port, frame state and the compare tasks
 */

`ifndef FLU_FRAME_MODEL_SVH
`define FLU_FRAME_MODEL_SVH

  // Wide enough for a whole bus word
  typedef logic [$bits(flu_word_t)-1:0] cmp_t;

  // Words pushed by each source, oldest first
  flu_word_t exp_q [INPUT_PORTS][$];
  // Port that owns the output while its frame is open
  int        lock_port  = -1;
  logic      model_open = 1'b0;
  // Round-robin order phase
  bit        rr_phase   = 1'b0;
  int        prev_port  = -1;

  // Frame still open once word w has passed
  function automatic logic open_after_word(flu_word_t w, logic was_open);
    if (w.sop && !w.eop) return 1'b1;
    // End of one frame, start of the next further on
    if (w.sop) return (int'(w.sop_pos) * BLOCK_SIZE) > int'(w.eop_pos);
    if (w.eop) return 1'b0;
    return was_open;
  endfunction

  // Expected word and its port, locked port first, else matching head
  function automatic flu_word_t expected_word(flu_word_t act, output int port);
    port = lock_port;
    if (port < 0) begin
      for (int p = 0; p < INPUT_PORTS; p++) begin
        if (port < 0 && exp_q[p].size() > 0 && exp_q[p][0] === act) port = p;
      end
    end
    if (port >= 0 && exp_q[port].size() > 0) return exp_q[port][0];
    // No candidate, report against the first pending head
    for (int p = 0; p < INPUT_PORTS; p++) begin
      if (exp_q[p].size() > 0) return exp_q[p][0];
    end
    return '0;
  endfunction

  function automatic int words_pending();
    int n;
    n = 0;
    for (int p = 0; p < INPUT_PORTS; p++) n += exp_q[p].size();
    return n;
  endfunction

  task automatic abort_run(string why);
    $display("Errors found");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(string name, cmp_t expected, cmp_t actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      abort_run("value mismatch on the output");
    end
  endtask

  // One word transferred on tx
  task automatic check_transfer(flu_word_t act);
    flu_word_t exp;
    int        port;
    exp = expected_word(act, port);
    check_value("tx_word", cmp_t'(exp), cmp_t'(act));
    if (port < 0 || exp_q[port].size() == 0) abort_run("output word with no pending input word");
    // Next port after the previous one
    if (rr_phase && prev_port >= 0) begin
      check_value("tx port", cmp_t'((prev_port + 1) % INPUT_PORTS), cmp_t'(port));
    end
    void'(exp_q[port].pop_front());
    model_open = open_after_word(act, model_open);
    lock_port  = model_open ? port : -1;
    prev_port  = rr_phase ? port : -1;
  endtask

`endif

// ==== sim/flu_binder_tb.sv ====
/*
 * Testbench for the FLU frame binder
 * Clock and reset, random sources and sink, timeout and output checks
 */

`default_nettype none

module flu_binder_tb
  import flu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int INPUT_PORTS    = 4;
  localparam int RESET_CYCLES   = 16;
  // Mixed frames first and one-word frames without gaps after them
  localparam int PHASE1_WORDS   = 40;
  localparam int PHASE2_WORDS   = 16;
  localparam int TOTAL_WORDS    = INPUT_PORTS * (PHASE1_WORDS + PHASE2_WORDS);
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_WORDS;

  logic                   clk = 1'b0;
  logic                   rst_n;
  flu_word_t              rx_word [INPUT_PORTS];
  logic [INPUT_PORTS-1:0] rx_src_rdy;
  logic [INPUT_PORTS-1:0] rx_dst_rdy;
  flu_word_t              tx_word;
  logic                   tx_src_rdy;
  logic                   tx_dst_rdy;
  integer                 seed = 32'hc43e_386d;
  int                     cycles = 0;

  `include "flu_frame_model.svh"

  flu_binder #(.INPUT_PORTS(INPUT_PORTS)) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_word    (rx_word),
    .rx_src_rdy (rx_src_rdy),
    .rx_dst_rdy (rx_dst_rdy),
    .tx_word    (tx_word),
    .tx_src_rdy (tx_src_rdy),
    .tx_dst_rdy (tx_dst_rdy)
  );

  // 10 ns period
  always #5 clk = ~clk;

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic flu_data_t rand_data();
    flu_data_t d;
    for (int i = 0; i < DATA_WIDTH / 32; i++) d[i*32 +: 32] = $random(seed);
    return d;
  endfunction

  // ----------------------------------------------------------------------
  // Sources
  // ----------------------------------------------------------------------

  // Random frames of 1 to 6 words whose last word always closes
  task automatic send_frames(int port, int n_words, bit rr_mode);
    flu_word_t w;
    int        left;
    int        lo;
    int        blk;
    bit        open;
    logic      xfer;
    open = 1'b0;
    left = 0;
    for (int n = 0; n < n_words; n++) begin
      w      = '0;
      w.data = rand_data();
      if (!open) begin
        // New frame on this word
        w.sop     = 1'b1;
        w.sop_pos = flu_sop_pos_t'(rand_below(4));
        left      = rr_mode ? 1 : 1 + rand_below(6);
        if (left > n_words - n) left = n_words - n;
        if (left == 1) begin
          lo        = int'(w.sop_pos) * BLOCK_SIZE;
          w.eop     = 1'b1;
          w.eop_pos = flu_eop_pos_t'(lo + rand_below(32 - lo));
        end else begin
          open = 1'b1;
        end
      end else if (left == 1) begin
        w.eop     = 1'b1;
        w.eop_pos = flu_eop_pos_t'(rand_below(32));
        open      = 1'b0;
        // Sometimes next frame starts in a later block of this word
        if (n < n_words - 1 && int'(w.eop_pos) < 24 && rand_below(2) == 1) begin
          blk       = int'(w.eop_pos) / BLOCK_SIZE;
          w.sop     = 1'b1;
          w.sop_pos = flu_sop_pos_t'(blk + 1 + rand_below(3 - blk));
          open      = 1'b1;
          left      = 2 + rand_below(5);
          if (left > n_words - n) left = n_words - n;
        end
      end
      left--;
      while (!rr_mode && rand_below(4) == 0) begin
        rx_src_rdy[port] = 1'b0;
        @(posedge clk);
        #1;
      end
      rx_word[port]    = w;
      rx_src_rdy[port] = 1'b1;
      exp_q[port].push_back(w);
      // Registered ready is stable at the falling edge
      do begin
        @(negedge clk);
        xfer = rx_dst_rdy[port];
        @(posedge clk);
        #1;
      end while (!xfer);
    end
    rx_src_rdy[port] = 1'b0;
  endtask

  task automatic run_sources(int n_words, bit rr_mode);
    for (int p = 0; p < INPUT_PORTS; p++) begin
      fork
        automatic int port = p;
        send_frames(port, n_words, rr_mode);
      join_none
    end
    wait fork;
  endtask

  task automatic wait_drained();
    do @(posedge clk);
    while (words_pending() != 0);
    // Output register empty once the last word has left
    @(negedge clk);
    check_value("tx_src_rdy", cmp_t'(0), cmp_t'(tx_src_rdy));
    @(posedge clk);
    #1;
  endtask

  // Random back-pressure
  initial begin
    tx_dst_rdy = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n) tx_dst_rdy = (rand_below(4) != 0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) abort_run("timeout, not all input words reached the output");
  end

  // Output transfers sampled away from the active edge
  always @(negedge clk) begin
    if (rst_n && tx_src_rdy && tx_dst_rdy) check_transfer(tx_word);
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_n      = 1'b0;
    rx_src_rdy = '0;
    for (int p = 0; p < INPUT_PORTS; p++) rx_word[p] = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // Empty output and all buffers ready
    @(negedge clk);
    check_value("tx_src_rdy", cmp_t'(0), cmp_t'(tx_src_rdy));
    check_value("rx_dst_rdy", cmp_t'({INPUT_PORTS{1'b1}}), cmp_t'(rx_dst_rdy));
    @(posedge clk);
    #1;
    run_sources(PHASE1_WORDS, 1'b0);
    wait_drained();
    // All ports loaded with one-word frames
    rr_phase = 1'b1;
    run_sources(PHASE2_WORDS, 1'b1);
    wait_drained();
    $display("No errors");
    $finish;
  end

endmodule : flu_binder_tb

`default_nettype wire

// ==== src/flu_binder.sv ====
/*
 * FLU frame binder top level
 * Per-port buffers, frame arbiter and output mux
 */

`default_nettype none

module flu_binder
  import flu_pkg::*;
#(
  // At least 2
  parameter int INPUT_PORTS = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Input streams
  input  flu_word_t              rx_word [INPUT_PORTS],
  input  logic [INPUT_PORTS-1:0] rx_src_rdy,
  output logic [INPUT_PORTS-1:0] rx_dst_rdy,
  // Merged stream
  output flu_word_t              tx_word,
  output logic                   tx_src_rdy,
  input  logic                   tx_dst_rdy
);

  flu_word_t              buf_word [INPUT_PORTS];
  logic [INPUT_PORTS-1:0] buf_vld;
  logic [INPUT_PORTS-1:0] buf_pop;
  logic [INPUT_PORTS-1:0] grant;
  logic                   mux_take;

  // One buffer per input port
  for (genvar i = 0; i < INPUT_PORTS; i++) begin : g_port
    flu_skid_buffer u_buf (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_word  (rx_word[i]),
      .in_vld   (rx_src_rdy[i]),
      .in_rdy   (rx_dst_rdy[i]),
      .out_word (buf_word[i]),
      .out_vld  (buf_vld[i]),
      .out_pop  (buf_pop[i])
    );
  end

  // Port selection
  frame_arbiter #(.INPUT_PORTS(INPUT_PORTS)) u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (buf_vld),
    .head_word (buf_word),
    .take      (mux_take),
    .grant     (grant)
  );

  // Output path
  flu_frame_mux #(.INPUT_PORTS(INPUT_PORTS)) u_mux (
    .clk        (clk),
    .rst_n      (rst_n),
    .grant      (grant),
    .head_word  (buf_word),
    .head_vld   (buf_vld),
    .pop        (buf_pop),
    .take       (mux_take),
    .tx_word    (tx_word),
    .tx_src_rdy (tx_src_rdy),
    .tx_dst_rdy (tx_dst_rdy)
  );

endmodule : flu_binder

`default_nettype wire

// ==== src/flu_frame_mux.sv ====
/*
 * Output multiplexer
 * Granted head word into the output register, with back-pressure
 */

`default_nettype none

module flu_frame_mux
  import flu_pkg::*;
#(
  parameter int INPUT_PORTS = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Arbiter and buffers
  input  logic [INPUT_PORTS-1:0] grant,
  input  flu_word_t              head_word [INPUT_PORTS],
  input  logic [INPUT_PORTS-1:0] head_vld,
  output logic [INPUT_PORTS-1:0] pop,
  output logic                   take,
  // Output bus
  output flu_word_t              tx_word,
  output logic                   tx_src_rdy,
  input  logic                   tx_dst_rdy
);

  flu_word_t sel_word;
  logic      sel_vld;
  logic      space;

  // Granted head, one-hot select
  always_comb begin
    sel_word = '0;
    for (int i = 0; i < INPUT_PORTS; i++) begin
      if (grant[i]) sel_word = head_word[i];
    end
  end

  assign sel_vld = |(grant & head_vld);

  // Register empty or draining this cycle
  assign space = ~tx_src_rdy | tx_dst_rdy;

  // Same condition loads register, pops buffer, informs arbiter
  assign take = space & sel_vld;
  assign pop  = take ? grant : '0;

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_src_rdy <= 1'b0;
    end else if (space) begin
      tx_src_rdy <= sel_vld;
    end
  end

  // Payload, holds under back-pressure
  always_ff @(posedge clk) begin
    if (take) tx_word <= sel_word;
  end

endmodule : flu_frame_mux

`default_nettype wire

// ==== src/frame_arbiter.sv ====
/*
 * Frame-granular round-robin arbiter
 * Grant locks to one port while its frame stays open
 */

`default_nettype none

module frame_arbiter
  import flu_pkg::*;
  import binder_pkg::*;
#(
  parameter int INPUT_PORTS = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Buffer heads
  input  logic [INPUT_PORTS-1:0] req,
  input  flu_word_t              head_word [INPUT_PORTS],
  // Word taken by the mux this cycle
  input  logic                   take,
  // One-hot port select
  output logic [INPUT_PORTS-1:0] grant
);

  localparam int IDX_W = $clog2(INPUT_PORTS);

  typedef logic [IDX_W-1:0] port_idx_t;

  arb_state_t             state_q;
  logic [INPUT_PORTS-1:0] lock_q;
  logic [INPUT_PORTS-1:0] rr_grant;
  port_idx_t              last_q;
  port_idx_t              grant_idx;
  logic                   open_nxt;

  // ----------------------------------------------------------------------
  // Round-robin search
  // ----------------------------------------------------------------------

  // Start one past the last granted port, wrap around
  always_comb begin
    int   idx;
    logic found;
    rr_grant = '0;
    found    = 1'b0;
    for (int i = 1; i <= INPUT_PORTS; i++) begin
      idx = (int'(last_q) + i) % INPUT_PORTS;
      if (!found && req[idx]) begin
        rr_grant[idx] = 1'b1;
        found         = 1'b1;
      end
    end
  end

  // Locked port holds grant even with empty buffer
  assign grant = (state_q == st_locked) ? lock_q : rr_grant;

  // Index of granted port
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < INPUT_PORTS; i++) begin
      if (grant[i]) grant_idx = port_idx_t'(i);
    end
  end

  // Frame state after the taken word
  // In idle no frame is open before the word
  assign open_nxt = frame_open_after(head_word[grant_idx], state_q == st_locked);

  // ----------------------------------------------------------------------
  // Lock control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= st_idle;
      lock_q  <= '0;
      // Port 0 first after reset
      last_q  <= port_idx_t'(INPUT_PORTS - 1);
    end else if (take) begin
      last_q <= grant_idx;
      if (open_nxt) begin
        state_q <= st_locked;
        lock_q  <= grant;
      end else begin
        // Frame closed on word boundary, rearbitrate
        state_q <= st_idle;
        lock_q  <= '0;
      end
    end
  end

endmodule : frame_arbiter

`default_nettype wire

// ==== src/flu_skid_buffer.sv ====
/*
 * Per-port input buffer
 * Two-entry FIFO with registered ready towards the sender
 */

`default_nettype none

module flu_skid_buffer
  import flu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  // Sender side
  input  flu_word_t in_word,
  input  logic      in_vld,
  output logic      in_rdy,
  // Head of buffer
  output flu_word_t out_word,
  output logic      out_vld,
  input  logic      out_pop
);

  // Two storage entries
  flu_word_t  mem [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic [1:0] count_nxt;
  logic       push;
  logic       pop;

  // Handshakes
  assign push = in_vld & in_rdy;
  assign pop  = out_pop & out_vld;

  // Head always shows oldest entry
  assign out_vld  = (count_q != 2'd0);
  assign out_word = mem[rd_ptr_q];

  // Fill level after this cycle
  assign count_nxt = count_q + 2'(push) - 2'(pop);

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q  <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      // Empty after reset and ready at once
      in_rdy   <= 1'b1;
    end else begin
      count_q <= count_nxt;
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      // Ready while a slot stays free next cycle
      in_rdy <= (count_nxt != 2'd2);
    end
  end

  // Entry write
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr_q] <= in_word;
  end

endmodule : flu_skid_buffer

`default_nettype wire

// ==== src/binder_pkg.sv ====
/*
 * Binder control definitions
 * Arbiter state encoding and the frame closure rule
 */

`default_nettype none

package binder_pkg;
  import flu_pkg::*;

  // Arbiter states
  typedef enum logic {
    st_idle,
    st_locked
  } arb_state_t;

  // Frame still open once this word has passed
  function automatic logic frame_open_after(flu_word_t w, logic was_open);
    flu_eop_pos_t start_byte;
    start_byte = flu_eop_pos_t'(int'(w.sop_pos) * BLOCK_SIZE);
    if (w.sop && !w.eop) return 1'b1;
    // Old frame ends, new one starts later in the same word
    if (w.sop && w.eop) return start_byte > w.eop_pos;
    if (!w.eop) return was_open;
    return 1'b0;
  endfunction

endpackage : binder_pkg

`default_nettype wire

// ==== src/flu_pkg.sv ====
/*
 * FrameLink Unaligned bus definitions
 * Field widths, vector types and the packed bus word
 */

`default_nettype none

package flu_pkg;

  // ----------------------------------------------------------------------
  // Bus geometry
  // ----------------------------------------------------------------------

  // 256 data bits, 32 bytes per word
  localparam int DATA_WIDTH    = 256;
  // Frames start on 8 byte block boundaries only
  localparam int BLOCK_SIZE    = 8;
  // Block index of a frame start, 4 blocks per word
  localparam int SOP_POS_WIDTH = 2;
  // Byte index of a frame end, 32 bytes per word
  localparam int EOP_POS_WIDTH = 5;

  // Field types
  typedef logic [DATA_WIDTH-1:0]    flu_data_t;
  typedef logic [SOP_POS_WIDTH-1:0] flu_sop_pos_t;
  typedef logic [EOP_POS_WIDTH-1:0] flu_eop_pos_t;

  // One bus word, handshake kept outside
  typedef struct packed {
    flu_data_t    data;
    flu_sop_pos_t sop_pos;
    flu_eop_pos_t eop_pos;
    logic         sop;
    logic         eop;
  } flu_word_t;

endpackage : flu_pkg

`default_nettype wire
